// ==== mcu_bus.f ====
+incdir+hw
hw/mcu_bus_pkg.sv
hw/bus_interconnect.sv
hw/axil_memory.sv
hw/uart_regs.sv
hw/uart_engine.sv
hw/sim_ctrl.sv
hw/mcu_bus_top.sv
verification/tb_mcu_bus.sv

// ==== verification/tb_mcu_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mcu_bus_cfg.svh"

module tb_mcu_bus;

    localparam int CLK_PERIOD   = 4;
    localparam int POLL_LIMIT   = 60;
    localparam int HOLD_CYCLES  = 5;
    // Longest entry is a poll that runs out at three cycles per read
    localparam int WORST_CYCLES = POLL_LIMIT * 3;
    localparam logic [31:0] MEM_BASE = 32'h0000_0100;

    // Entry kinds
    localparam int OP_WR   = 0;
    localparam int OP_RD   = 1;
    localparam int OP_POLL = 2;
    localparam int OP_PIN  = 3;
    localparam int OP_HOLD = 4;

    typedef struct {
        string                   name;
        int                      op;
        logic [31:0]             addr;
        logic [31:0]             data;
        logic [3:0]              strb;
        logic [31:0]             mask;
        logic [31:0]             exp;
        mcu_bus_pkg::axil_resp_e resp;
    } test_entry_t;

    logic                   clk;
    logic                   reset;
    logic                   halt;
    logic                   table_ready = 1'b0;
    wire                    uart_loop;
    logic [31:0]            seed;
    logic [31:0]            model [`MCU_MEM_WORDS];
    test_entry_t            tests [$];
    mcu_bus_pkg::axil_req_t host_req;
    mcu_bus_pkg::axil_rsp_t host_rsp;

    // Serial output fed straight back into the receiver
    mcu_bus_top i_dut (
        .clk(clk), .reset(reset),
        .host_req(host_req), .host_rsp(host_rsp),
        .uart_rx(uart_loop), .uart_tx(uart_loop), .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int mem_index(input logic [31:0] addr);
        return (addr >> 2) % `MCU_MEM_WORDS;
    endfunction

    function automatic logic [31:0] uart_addr(input mcu_bus_pkg::uart_reg_e r);
        return `MCU_S1_BASE + 32'(r) * 4;
    endfunction

    // Reference memory where only strobed lanes change
    task automatic model_write(input logic [31:0] addr, data, input logic [3:0] strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) model[mem_index(addr)][8*i +: 8] = data[8*i +: 8];
        end
    endtask

    task automatic add_test(input string name, input int op, input logic [31:0] addr, data,
                            input logic [3:0] strb, input logic [31:0] mask, exp,
                            input mcu_bus_pkg::axil_resp_e resp);
        test_entry_t t;
        t = '{name, op, addr, data, strb, mask, exp, resp};
        tests.push_back(t);
    endtask

    // ====================
    // Stimulus table
    // ====================
    task automatic build_table();
        logic [31:0] a;
        logic [31:0] st;
        logic [31:0] sg;
        st = uart_addr(mcu_bus_pkg::REG_STATUS);
        // Full words then one byte lane over the second word
        for (int k = 0; k < 4; k++) begin
            a = MEM_BASE + 32'(k) * 4;
            seed = next_random(seed);
            model_write(a, seed, 4'hF);
            add_test($sformatf("mem_write_%0d", k), OP_WR, a, seed, 4'hF, 0, 0, mcu_bus_pkg::OKAY);
        end
        seed = next_random(seed);
        model_write(MEM_BASE + 4, seed, 4'b0100);
        add_test("mem_write_byte", OP_WR, MEM_BASE + 4, seed, 4'b0100, 0, 0, mcu_bus_pkg::OKAY);
        for (int k = 0; k < 4; k++) begin
            a = MEM_BASE + 32'(k) * 4;
            add_test($sformatf("mem_read_%0d", k), OP_RD, a, 0, 0, '1, model[mem_index(a)],
                     mcu_bus_pkg::OKAY);
        end
        // One full memory depth further wraps to the base word
        add_test("mem_alias", OP_RD, MEM_BASE + `MCU_MEM_WORDS * 4, 0, 0, '1,
                 model[mem_index(MEM_BASE)], mcu_bus_pkg::OKAY);

        add_test("decerr_read", OP_RD, 32'h5000_0000, 0, 0, '1, 0, mcu_bus_pkg::DECERR);
        add_test("decerr_write", OP_WR, 32'h5000_0000, 32'h1234, 4'hF, 0, 0,
                 mcu_bus_pkg::DECERR);
        add_test("decerr_past_uart", OP_RD, `MCU_S1_LAST + 1, 0, 0, '1, 0, mcu_bus_pkg::DECERR);

        // UART setup and single loopback frame
        a = uart_addr(mcu_bus_pkg::REG_BAUD);
        add_test("uart_baud_write", OP_WR, a, 8, 4'hF, 0, 0, mcu_bus_pkg::OKAY);
        add_test("uart_baud_read", OP_RD, a, 0, 0, '1, 8, mcu_bus_pkg::OKAY);
        add_test("uart_tx_idle_0", OP_POLL, st, 0, 0, 32'h1, 0, mcu_bus_pkg::OKAY);
        a = uart_addr(mcu_bus_pkg::REG_TXDATA);
        add_test("uart_send_a5", OP_WR, a, 32'hA5, 4'hF, 0, 0, mcu_bus_pkg::OKAY);
        add_test("uart_rx_poll_0", OP_POLL, st, 0, 0, 32'h2, 32'h2, mcu_bus_pkg::OKAY);
        a = uart_addr(mcu_bus_pkg::REG_RXDATA);
        add_test("uart_rx_a5", OP_RD, a, 0, 0, '1, 32'hA5, mcu_bus_pkg::OKAY);
        add_test("uart_rx_cleared", OP_RD, st, 0, 0, 32'h2, 0, mcu_bus_pkg::OKAY);

        // Busy reject then overrun from two unread frames
        a = uart_addr(mcu_bus_pkg::REG_TXDATA);
        add_test("uart_tx_idle_1", OP_POLL, st, 0, 0, 32'h1, 0, mcu_bus_pkg::OKAY);
        add_test("uart_send_3c", OP_WR, a, 32'h3C, 4'hF, 0, 0, mcu_bus_pkg::OKAY);
        add_test("uart_busy_reject", OP_WR, a, 32'h99, 4'hF, 0, 0, mcu_bus_pkg::SLVERR);
        add_test("uart_rx_poll_1", OP_POLL, st, 0, 0, 32'h2, 32'h2, mcu_bus_pkg::OKAY);
        add_test("uart_tx_idle_2", OP_POLL, st, 0, 0, 32'h1, 0, mcu_bus_pkg::OKAY);
        add_test("uart_send_5a", OP_WR, a, 32'h5A, 4'hF, 0, 0, mcu_bus_pkg::OKAY);
        add_test("uart_overrun_poll", OP_POLL, st, 0, 0, 32'h4, 32'h4, mcu_bus_pkg::OKAY);
        add_test("uart_overrun_status", OP_RD, st, 0, 0, 32'h6, 32'h6, mcu_bus_pkg::OKAY);
        add_test("uart_rx_last", OP_RD, uart_addr(mcu_bus_pkg::REG_RXDATA), 0, 0, '1, 32'h5A,
                 mcu_bus_pkg::OKAY);
        add_test("uart_flags_cleared", OP_RD, st, 0, 0, 32'h6, 0, mcu_bus_pkg::OKAY);

        // Signature and sticky halt
        seed = next_random(seed);
        sg = seed;
        add_test("halt_low_reset", OP_PIN, 0, 0, 0, 32'h1, 0, mcu_bus_pkg::OKAY);
        add_test("sig_write", OP_WR, `MCU_S2_BASE, sg, 4'hF, 0, 0, mcu_bus_pkg::OKAY);
        add_test("sig_read", OP_RD, `MCU_S2_BASE, 0, 0, '1, sg, mcu_bus_pkg::OKAY);
        add_test("halt_reg_low", OP_RD, `MCU_S2_BASE + 4, 0, 0, '1, 0, mcu_bus_pkg::OKAY);
        add_test("halt_still_low", OP_PIN, 0, 0, 0, 32'h1, 0, mcu_bus_pkg::OKAY);
        add_test("halt_write", OP_WR, `MCU_S2_BASE + 4, 1, 4'hF, 0, 0, mcu_bus_pkg::OKAY);
        add_test("halt_pin_high", OP_PIN, 0, 0, 0, 32'h1, 1, mcu_bus_pkg::OKAY);
        add_test("halt_reg_high", OP_RD, `MCU_S2_BASE + 4, 0, 0, '1, 1, mcu_bus_pkg::OKAY);
        add_test("sig_rewrite", OP_WR, `MCU_S2_BASE, ~sg, 4'hF, 0, 0, mcu_bus_pkg::OKAY);
        add_test("halt_sticky", OP_PIN, 0, 0, 0, 32'h1, 1, mcu_bus_pkg::OKAY);

        // Read response held under back-pressure
        add_test("mem_backpressure", OP_HOLD, MEM_BASE + 4, 0, 0, '1,
                 model[mem_index(MEM_BASE + 4)], mcu_bus_pkg::OKAY);
        add_test("sig_backpressure", OP_HOLD, `MCU_S2_BASE, 0, 0, '1, ~sg, mcu_bus_pkg::OKAY);
    endtask

    // ====================
    // Host bus tasks
    // ====================
    task automatic bus_write(input logic [31:0] addr, data, input logic [3:0] strb,
                             output mcu_bus_pkg::axil_resp_e resp);
        @(negedge clk);
        host_req.awvalid = 1'b1;
        host_req.wvalid  = 1'b1;
        host_req.awaddr  = addr;
        host_req.wdata   = data;
        host_req.wstrb   = strb;
        host_req.bready  = 1'b1;
        #1;
        // Address and data taken together
        while (!(host_rsp.awready && host_rsp.wready)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        host_req.awvalid = 1'b0;
        host_req.wvalid  = 1'b0;
        #1;
        while (!host_rsp.bvalid) begin
            @(negedge clk);
            #1;
        end
        resp = host_rsp.bresp;
        @(negedge clk);
        host_req.bready = 1'b0;
    endtask

    task automatic bus_read(input string name, input logic [31:0] addr, input bit hold,
                            output logic [31:0] data, output mcu_bus_pkg::axil_resp_e resp,
                            inout bit ok);
        logic [31:0] first;
        @(negedge clk);
        host_req.arvalid = 1'b1;
        host_req.araddr  = addr;
        host_req.rready  = !hold;
        #1;
        while (!host_rsp.arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        host_req.arvalid = 1'b0;
        #1;
        while (!host_rsp.rvalid) begin
            @(negedge clk);
            #1;
        end
        if (hold) begin
            first = host_rsp.rdata;
            // Response must stay put while rready is low
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                #1;
                if (!host_rsp.rvalid || host_rsp.rdata !== first) begin
                    $display("%s: read response dropped or changed while rready was low", name);
                    ok = 1'b0;
                end
            end
            @(negedge clk);
            host_req.rready = 1'b1;
            #1;
        end
        data = host_rsp.rdata;
        resp = host_rsp.rresp;
        @(negedge clk);
        host_req.rready = 1'b0;
    endtask

    // ====================
    // Checks
    // ====================
    task automatic check_value(input string name, input logic [31:0] exp, act, mask,
                               inout bit ok);
        if ((act & mask) !== (exp & mask)) begin
            $display("** Error %s: expected %h, actual %h", name, exp & mask, act & mask);
            ok = 1'b0;
        end
    endtask

    task automatic check_resp(input string name, input mcu_bus_pkg::axil_resp_e exp, act,
                              inout bit ok);
        if (act !== exp) begin
            $display("** Error %s: expected %s, actual %s", name, exp.name(), act.name());
            ok = 1'b0;
        end
    endtask

    task automatic apply_entry(input test_entry_t t, output bit ok);
        logic [31:0]             rd;
        mcu_bus_pkg::axil_resp_e rs;
        int                      n;
        ok = 1'b1;
        case (t.op)
            OP_WR: begin
                bus_write(t.addr, t.data, t.strb, rs);
                check_resp(t.name, t.resp, rs, ok);
            end
            OP_RD, OP_HOLD: begin
                bus_read(t.name, t.addr, (t.op == OP_HOLD), rd, rs, ok);
                check_resp(t.name, t.resp, rs, ok);
                check_value(t.name, t.exp, rd, t.mask, ok);
            end
            OP_POLL: begin
                // Bounded status polling
                n = 0;
                do begin
                    bus_read(t.name, t.addr, 1'b0, rd, rs, ok);
                    n++;
                end while (((rd & t.mask) !== t.exp) && n < POLL_LIMIT);
                if ((rd & t.mask) !== t.exp) begin
                    if (t.mask[0]) $display("%s: UART transmitter never went idle", t.name);
                    else $display("%s: UART status never showed received byte", t.name);
                    ok = 1'b0;
                end
            end
            default: check_value(t.name, t.exp, {31'd0, halt}, t.mask, ok);
        endcase
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        bit ok;
        int n_pass;
        int n_fail;
        n_pass   = 0;
        n_fail   = 0;
        host_req = '0;
        reset    = 1'b1;
        seed     = 32'h08e823ad;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < tests.size(); i++) begin
            apply_entry(tests[i], ok);
            if (ok) begin
                n_pass++;
                $display("[pass] %s", tests[i].name);
            end else begin
                n_fail++;
                $display("[FAIL] %s", tests[i].name);
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d", tests.size(), n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Budget is every entry at its worst plus 12 frames at divisor 8
    initial begin
        longint limit;
        wait (table_ready);
        limit = (longint'(tests.size()) * WORST_CYCLES + 12 * 10 * 8 + 10) * CLK_PERIOD;
        #(limit);
        $display("Watchdog expired after %0d ns, the tests did not finish", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/mcu_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcu_bus_top (
    input  logic                   clk,
    input  logic                   reset,
    input  mcu_bus_pkg::axil_req_t host_req,
    output mcu_bus_pkg::axil_rsp_t host_rsp,
    input  logic                   uart_rx,
    output logic                   uart_tx,
    output logic                   halt
);

    // Per-slave links
    mcu_bus_pkg::axil_req_t mem_req, uart_req, sim_req;
    mcu_bus_pkg::axil_rsp_t mem_rsp, uart_rsp, sim_rsp;

    // Register block to engine
    logic        tx_start, tx_busy, rx_ack, rx_valid, rx_overrun;
    logic [7:0]  tx_byte, rx_byte;
    logic [15:0] baud_div;

    // ====================
    // Interconnect
    // ====================
    bus_interconnect i_interconnect (
        .clk(clk), .reset(reset),
        .host_req(host_req), .host_rsp(host_rsp),
        .mem_req(mem_req), .uart_req(uart_req), .sim_req(sim_req),
        .mem_rsp(mem_rsp), .uart_rsp(uart_rsp), .sim_rsp(sim_rsp)
    );

    // ====================
    // Slaves
    // ====================
    axil_memory i_memory (.clk(clk), .reset(reset), .req(mem_req), .rsp(mem_rsp));

    uart_regs i_uart_regs (
        .clk(clk), .reset(reset), .req(uart_req), .rsp(uart_rsp),
        .tx_start(tx_start), .tx_byte(tx_byte), .baud_div(baud_div), .rx_ack(rx_ack),
        .tx_busy(tx_busy), .rx_byte(rx_byte), .rx_valid(rx_valid), .rx_overrun(rx_overrun)
    );

    uart_engine i_uart_engine (
        .clk(clk), .reset(reset),
        .tx_start(tx_start), .tx_byte(tx_byte), .baud_div(baud_div), .rx_ack(rx_ack),
        .tx_busy(tx_busy), .rx_byte(rx_byte), .rx_valid(rx_valid), .rx_overrun(rx_overrun),
        .uart_rx(uart_rx), .uart_tx(uart_tx)
    );

    sim_ctrl i_sim_ctrl (.clk(clk), .reset(reset), .req(sim_req), .rsp(sim_rsp), .halt(halt));

endmodule

`default_nettype wire

// ==== hw/sim_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sim_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  mcu_bus_pkg::axil_req_t req,
    output mcu_bus_pkg::axil_rsp_t rsp,
    output logic                   halt
);

    logic [31:0] signature, rdata;
    logic        bvalid, rvalid;
    logic        wr_go, rd_go;

    assign wr_go = req.awvalid && req.wvalid && !bvalid;
    assign rd_go = req.arvalid && !rvalid;

    // Offset 0 signature, offset 4 halt
    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            halt      <= 1'b0;
            signature <= '0;
            rdata     <= '0;
        end else begin
            if (wr_go) begin
                bvalid <= 1'b1;
                // Halt sticks until reset
                if (req.awaddr[2]) halt <= 1'b1;
                else signature <= req.wdata;
            end else if (req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_go) begin
                rvalid <= 1'b1;
                rdata  <= req.araddr[2] ? {31'd0, halt} : signature;
            end else if (req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    assign rsp = '{awready: wr_go, wready: wr_go, bvalid: bvalid, bresp: mcu_bus_pkg::OKAY,
                   arready: rd_go, rvalid: rvalid, rdata: rdata, rresp: mcu_bus_pkg::OKAY};

endmodule

`default_nettype wire

// ==== hw/uart_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_engine (
    input  logic        clk,
    input  logic        reset,
    input  logic        tx_start,
    input  logic [7:0]  tx_byte,
    input  logic [15:0] baud_div,
    input  logic        rx_ack,
    output logic        tx_busy,
    output logic [7:0]  rx_byte,
    output logic        rx_valid,
    output logic        rx_overrun,
    input  logic        uart_rx,
    output logic        uart_tx
);

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} uart_state_e;

    uart_state_e tx_state, rx_state;
    logic [15:0] tx_cnt, rx_cnt;
    logic [2:0]  tx_bit, rx_bit;
    logic [7:0]  tx_shift, rx_shift;
    logic        rx_meta, rx_sync, rx_sync_d;
    logic        tx_tick, rx_tick, rx_mid;

    assign tx_busy = (tx_state != ST_IDLE);
    assign tx_tick = (tx_cnt == baud_div - 16'd1);
    assign rx_tick = (rx_cnt == baud_div - 16'd1);
    // Half period into the start bit
    assign rx_mid  = (rx_cnt == (baud_div >> 1));

    // ====================
    // Transmitter
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_state <= ST_IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            tx_shift <= '0;
            uart_tx  <= 1'b1;
        end else if (tx_state == ST_IDLE) begin
            uart_tx <= 1'b1;
            if (tx_start) begin
                tx_shift <= tx_byte;
                tx_cnt   <= '0;
                uart_tx  <= 1'b0;
                tx_state <= ST_START;
            end
        end else if (!tx_tick) begin
            tx_cnt <= tx_cnt + 16'd1;
        end else begin
            tx_cnt <= '0;
            case (tx_state)
                ST_START: begin
                    // LSB first
                    uart_tx  <= tx_shift[0];
                    tx_shift <= tx_shift >> 1;
                    tx_bit   <= '0;
                    tx_state <= ST_DATA;
                end
                ST_DATA: begin
                    if (tx_bit == 3'd7) begin
                        uart_tx  <= 1'b1;
                        tx_state <= ST_STOP;
                    end else begin
                        uart_tx  <= tx_shift[0];
                        tx_shift <= tx_shift >> 1;
                        tx_bit   <= tx_bit + 3'd1;
                    end
                end
                default: tx_state <= ST_IDLE;
            endcase
        end
    end

    // Two-flop synchronizer plus edge history that idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta   <= 1'b1;
            rx_sync   <= 1'b1;
            rx_sync_d <= 1'b1;
        end else begin
            rx_meta   <= uart_rx;
            rx_sync   <= rx_meta;
            rx_sync_d <= rx_sync;
        end
    end

    // ====================
    // Receiver
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_state   <= ST_IDLE;
            rx_cnt     <= '0;
            rx_bit     <= '0;
            rx_shift   <= '0;
            rx_byte    <= '0;
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            // Host read clears both flags
            if (rx_ack) begin
                rx_valid   <= 1'b0;
                rx_overrun <= 1'b0;
            end
            case (rx_state)
                ST_IDLE: begin
                    rx_cnt <= '0;
                    if (rx_sync_d && !rx_sync) rx_state <= ST_START;
                end
                ST_START: begin
                    rx_cnt <= rx_cnt + 16'd1;
                    if (rx_mid) begin
                        rx_cnt <= '0;
                        rx_bit <= '0;
                        // Line back high means a glitch
                        rx_state <= rx_sync ? ST_IDLE : ST_DATA;
                    end
                end
                ST_DATA: begin
                    rx_cnt <= rx_cnt + 16'd1;
                    if (rx_tick) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_sync, rx_shift[7:1]};
                        rx_bit   <= rx_bit + 3'd1;
                        if (rx_bit == 3'd7) rx_state <= ST_STOP;
                    end
                end
                default: begin
                    rx_cnt <= rx_cnt + 16'd1;
                    if (rx_tick) begin
                        rx_state <= ST_IDLE;
                        // Framing error drops the byte
                        if (rx_sync) begin
                            rx_byte    <= rx_shift;
                            rx_valid   <= 1'b1;
                            // A read in the same cycle still clears it
                            rx_overrun <= (rx_overrun || rx_valid) && !rx_ack;
                        end
                    end
                end
            endcase
        end
    end

    // A held overrun always has a byte behind it
    a_overrun_has_byte: assert property (@(posedge clk) disable iff (reset)
        rx_overrun |-> rx_valid);

endmodule

`default_nettype wire

// ==== hw/uart_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mcu_bus_cfg.svh"

module uart_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  mcu_bus_pkg::axil_req_t req,
    output mcu_bus_pkg::axil_rsp_t rsp,
    output logic                   tx_start,
    output logic [7:0]             tx_byte,
    output logic [15:0]            baud_div,
    output logic                   rx_ack,
    input  logic                   tx_busy,
    input  logic [7:0]             rx_byte,
    input  logic                   rx_valid,
    input  logic                   rx_overrun
);

    mcu_bus_pkg::uart_reg_e  wr_reg, rd_reg;
    mcu_bus_pkg::axil_resp_e bresp;
    logic [31:0] rdata;
    logic        bvalid, rvalid;
    logic        wr_go, rd_go;

    assign wr_go  = req.awvalid && req.wvalid && !bvalid;
    assign rd_go  = req.arvalid && !rvalid;
    assign wr_reg = mcu_bus_pkg::uart_reg_e'(req.awaddr[3:2]);
    assign rd_reg = mcu_bus_pkg::uart_reg_e'(req.araddr[3:2]);

    // Engine strobes fire on the accepting cycle
    assign tx_start = wr_go && (wr_reg == mcu_bus_pkg::REG_TXDATA) && !tx_busy;
    assign tx_byte  = req.wdata[7:0];
    assign rx_ack   = rd_go && (rd_reg == mcu_bus_pkg::REG_RXDATA);

    // ====================
    // Write side
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid   <= 1'b0;
            bresp    <= mcu_bus_pkg::OKAY;
            baud_div <= 16'(`MCU_BAUD_DIV);
        end else if (wr_go) begin
            bvalid <= 1'b1;
            bresp  <= mcu_bus_pkg::OKAY;
            // Transmitter busy rejects the byte
            if (wr_reg == mcu_bus_pkg::REG_TXDATA && tx_busy) bresp <= mcu_bus_pkg::SLVERR;
            if (wr_reg == mcu_bus_pkg::REG_BAUD) baud_div <= req.wdata[15:0];
        end else if (req.bready) begin
            bvalid <= 1'b0;
        end
    end

    // ====================
    // Read side
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else if (rd_go) begin
            rvalid <= 1'b1;
            case (rd_reg)
                mcu_bus_pkg::REG_RXDATA: rdata <= {24'd0, rx_byte};
                mcu_bus_pkg::REG_STATUS: rdata <= {29'd0, rx_overrun, rx_valid, tx_busy};
                mcu_bus_pkg::REG_BAUD:   rdata <= {16'd0, baud_div};
                default:                 rdata <= '0;
            endcase
        end else if (req.rready) begin
            rvalid <= 1'b0;
        end
    end

    assign rsp = '{awready: wr_go, wready: wr_go, bvalid: bvalid, bresp: bresp,
                   arready: rd_go, rvalid: rvalid, rdata: rdata, rresp: mcu_bus_pkg::OKAY};

endmodule

`default_nettype wire

// ==== hw/axil_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mcu_bus_cfg.svh"

module axil_memory (
    input  logic                   clk,
    input  logic                   reset,
    input  mcu_bus_pkg::axil_req_t req,
    output mcu_bus_pkg::axil_rsp_t rsp
);

    localparam int IDX_W = $clog2(`MCU_MEM_WORDS);

    logic [31:0] mem [`MCU_MEM_WORDS];
    logic [31:0] rdata;
    logic        bvalid, rvalid;
    logic        wr_go, rd_go;

    // Accept in the cycle the valids show, unless a response is pending
    assign wr_go = req.awvalid && req.wvalid && !bvalid;
    assign rd_go = req.arvalid && !rvalid;

    // Response valids
    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_go) bvalid <= 1'b1;
            else if (req.bready) bvalid <= 1'b0;
            if (rd_go) rvalid <= 1'b1;
            else if (req.rready) rvalid <= 1'b0;
        end
    end

    // Word index wraps at the depth
    always_ff @(posedge clk) begin
        if (wr_go) begin
            for (int i = 0; i < 4; i++) begin
                if (req.wstrb[i]) mem[req.awaddr[IDX_W+1:2]][8*i +: 8] <= req.wdata[8*i +: 8];
            end
        end
        if (rd_go) rdata <= mem[req.araddr[IDX_W+1:2]];
    end

    assign rsp = '{awready: wr_go, wready: wr_go, bvalid: bvalid, bresp: mcu_bus_pkg::OKAY,
                   arready: rd_go, rvalid: rvalid, rdata: rdata, rresp: mcu_bus_pkg::OKAY};

    // Read data held until taken
    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !req.rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

// ==== hw/bus_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mcu_bus_cfg.svh"

module bus_interconnect (
    input  logic                   clk,
    input  logic                   reset,
    input  mcu_bus_pkg::axil_req_t host_req,
    output mcu_bus_pkg::axil_rsp_t host_rsp,
    output mcu_bus_pkg::axil_req_t mem_req,
    output mcu_bus_pkg::axil_req_t uart_req,
    output mcu_bus_pkg::axil_req_t sim_req,
    input  mcu_bus_pkg::axil_rsp_t mem_rsp,
    input  mcu_bus_pkg::axil_rsp_t uart_rsp,
    input  mcu_bus_pkg::axil_rsp_t sim_rsp
);

    // Region lookup
    function automatic mcu_bus_pkg::slave_sel_e decode(input logic [31:0] addr);
        if (addr >= `MCU_S0_BASE && addr <= `MCU_S0_LAST) return mcu_bus_pkg::SEL_MEM;
        if (addr >= `MCU_S1_BASE && addr <= `MCU_S1_LAST) return mcu_bus_pkg::SEL_UART;
        if (addr >= `MCU_S2_BASE && addr <= `MCU_S2_LAST) return mcu_bus_pkg::SEL_SIM;
        return mcu_bus_pkg::SEL_NONE;
    endfunction

    mcu_bus_pkg::slave_sel_e aw_dec, ar_dec, wr_sel, rd_sel, wr_cur, rd_cur;
    mcu_bus_pkg::axil_req_t  slv_req [3];
    mcu_bus_pkg::axil_rsp_t  slv_rsp [3];
    logic wr_open, rd_open;
    logic dec_aw, dec_ar, dec_bvalid, dec_rvalid;
    logic wr_accept, rd_accept, wr_done, rd_done;

    assign aw_dec = decode(host_req.awaddr);
    assign ar_dec = decode(host_req.araddr);
    // Held selection while a transaction is open
    assign wr_cur = wr_open ? wr_sel : aw_dec;
    assign rd_cur = rd_open ? rd_sel : ar_dec;

    // ====================
    // Request fan-out
    // ====================
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            slv_req[i] = host_req;
            // New requests only when the channel is idle
            slv_req[i].awvalid = host_req.awvalid && !wr_open &&
                                 (aw_dec == mcu_bus_pkg::slave_sel_e'(i));
            slv_req[i].wvalid  = host_req.wvalid && !wr_open &&
                                 (aw_dec == mcu_bus_pkg::slave_sel_e'(i));
            slv_req[i].arvalid = host_req.arvalid && !rd_open &&
                                 (ar_dec == mcu_bus_pkg::slave_sel_e'(i));
            slv_req[i].bready  = host_req.bready && (wr_cur == mcu_bus_pkg::slave_sel_e'(i));
            slv_req[i].rready  = host_req.rready && (rd_cur == mcu_bus_pkg::slave_sel_e'(i));
        end
    end

    assign mem_req    = slv_req[0];
    assign uart_req   = slv_req[1];
    assign sim_req    = slv_req[2];
    assign slv_rsp[0] = mem_rsp;
    assign slv_rsp[1] = uart_rsp;
    assign slv_rsp[2] = sim_rsp;

    // Unmapped accesses taken at once
    assign dec_aw = host_req.awvalid && host_req.wvalid && !wr_open &&
                    (aw_dec == mcu_bus_pkg::SEL_NONE);
    assign dec_ar = host_req.arvalid && !rd_open && (ar_dec == mcu_bus_pkg::SEL_NONE);

    // ====================
    // Response mux
    // ====================
    always_comb begin
        host_rsp = '0;
        if (wr_cur == mcu_bus_pkg::SEL_NONE) begin
            host_rsp.awready = dec_aw;
            host_rsp.wready  = dec_aw;
            host_rsp.bvalid  = dec_bvalid;
            host_rsp.bresp   = mcu_bus_pkg::DECERR;
        end else begin
            host_rsp.awready = slv_rsp[wr_cur].awready;
            host_rsp.wready  = slv_rsp[wr_cur].wready;
            host_rsp.bvalid  = slv_rsp[wr_cur].bvalid;
            host_rsp.bresp   = slv_rsp[wr_cur].bresp;
        end
        if (rd_cur == mcu_bus_pkg::SEL_NONE) begin
            // Read data stays zero
            host_rsp.arready = dec_ar;
            host_rsp.rvalid  = dec_rvalid;
            host_rsp.rresp   = mcu_bus_pkg::DECERR;
        end else begin
            host_rsp.arready = slv_rsp[rd_cur].arready;
            host_rsp.rvalid  = slv_rsp[rd_cur].rvalid;
            host_rsp.rdata   = slv_rsp[rd_cur].rdata;
            host_rsp.rresp   = slv_rsp[rd_cur].rresp;
        end
    end

    assign wr_accept = host_req.awvalid && host_rsp.awready;
    assign rd_accept = host_req.arvalid && host_rsp.arready;
    assign wr_done   = host_rsp.bvalid && host_req.bready;
    assign rd_done   = host_rsp.rvalid && host_req.rready;

    // Channel tracking and DECERR responder
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_open    <= 1'b0;
            rd_open    <= 1'b0;
            wr_sel     <= mcu_bus_pkg::SEL_NONE;
            rd_sel     <= mcu_bus_pkg::SEL_NONE;
            dec_bvalid <= 1'b0;
            dec_rvalid <= 1'b0;
        end else begin
            if (wr_accept) begin
                wr_open <= 1'b1;
                wr_sel  <= aw_dec;
            end else if (wr_done) begin
                wr_open <= 1'b0;
            end
            if (rd_accept) begin
                rd_open <= 1'b1;
                rd_sel  <= ar_dec;
            end else if (rd_done) begin
                rd_open <= 1'b0;
            end
            if (dec_aw) dec_bvalid <= 1'b1;
            else if (host_req.bready) dec_bvalid <= 1'b0;
            if (dec_ar) dec_rvalid <= 1'b1;
            else if (host_req.rready) dec_rvalid <= 1'b0;
        end
    end

    // Slave responses only belong to an open, mapped transaction
    a_wr_sel_mapped: assert property (@(posedge clk) disable iff (reset)
        (mem_rsp.bvalid || uart_rsp.bvalid || sim_rsp.bvalid) |->
        (wr_open && wr_sel != mcu_bus_pkg::SEL_NONE));
    a_rd_sel_mapped: assert property (@(posedge clk) disable iff (reset)
        (mem_rsp.rvalid || uart_rsp.rvalid || sim_rsp.rvalid) |->
        (rd_open && rd_sel != mcu_bus_pkg::SEL_NONE));
    a_aw_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({mem_req.awvalid, uart_req.awvalid, sim_req.awvalid}));

endmodule

`default_nettype wire

// ==== hw/mcu_bus_pkg.sv ====
`default_nettype none

package mcu_bus_pkg;

    // AXI4-Lite response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_e;

    // Master side of one AXI4-Lite link
    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axil_req_t;

    // Slave side of one AXI4-Lite link
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        axil_resp_e  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        axil_resp_e  rresp;
    } axil_rsp_t;

    // Interconnect target, order matches slave port index
    typedef enum logic [1:0] {SEL_MEM, SEL_UART, SEL_SIM, SEL_NONE} slave_sel_e;

    // UART register word offsets
    typedef enum logic [1:0] {REG_TXDATA, REG_RXDATA, REG_STATUS, REG_BAUD} uart_reg_e;

endpackage

`default_nettype wire

// ==== hw/mcu_bus_cfg.svh ====
`ifndef MCU_BUS_CFG_SVH
`define MCU_BUS_CFG_SVH

// ====================
// Address map
// ====================

// Data memory
`define MCU_S0_BASE 32'h0000_0000
`define MCU_S0_LAST 32'h3FFF_FFFF
// UART register block, four words
`define MCU_S1_BASE 32'h4000_0000
`define MCU_S1_LAST 32'h4000_000F
// Simulation control, signature and halt
`define MCU_S2_BASE 32'hF000_0000
`define MCU_S2_LAST 32'hF000_0007

// Data memory depth in 32-bit words
`define MCU_MEM_WORDS 256

// UART timing, divisor is clocks per bit
`define MCU_CLOCK_FREQUENCY 100_000_000
`define MCU_BAUD_RATE 115_200
`define MCU_BAUD_DIV (`MCU_CLOCK_FREQUENCY / `MCU_BAUD_RATE)

`endif
